//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal --top-module $(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

int unsigned pc_w;             // next free program word
logic [31:0] exp_addr [$];     // expected stores, in program order
logic [31:0] exp_data [$];
logic [31:0] ref_image [1024]; // memory as the model leaves it

function automatic logic [31:0] enc(input opcode_e op, input int ra, input int rb, input int c);
    return {op, 4'(ra), 4'(rb), 19'(c)};
endfunction

// rc sits at the top of the constant field
function automatic logic [31:0] enc3(input opcode_e op, input int ra, input int rb, input int rc);
    return enc(op, ra, rb, rc << 15);
endfunction

task automatic emit(input logic [31:0] w);
    mem[pc_w] = w;
    pc_w++;
endtask

task automatic program_arith();
    int a;
    int b;
    int k;
    a = $random(seed) % 40000;
    b = $random(seed) % 200000;
    emit(enc(op_ldi, 1, 0, a));
    emit(enc(op_ldi, 2, 0, b));
    emit(enc(op_ldi, 3, 1, 17));      // base plus constant
    emit(enc3(op_add, 4, 1, 2));
    emit(enc3(op_sub, 5, 1, 2));
    emit(enc3(op_and, 6, 1, 2));
    emit(enc3(op_or, 7, 1, 2));
    emit(enc(op_addi, 8, 2, -77));
    emit(enc(op_nop, 0, 0, 0));
    emit(enc3(op_neg, 9, 1, 0));
    emit(enc3(op_not, 10, 2, 0));
    emit(enc3(op_sub, 11, 9, 10));    // chained results
    for (k = 3; k <= 11; k++) begin
        emit(enc(op_st, k, 0, 'h200 + k));
    end
    emit(enc(op_halt, 0, 0, 0));
endtask

task automatic program_load_store();
    int k;
    emit(enc(op_ldi, 1, 0, 'h300));
    for (k = 0; k < 4; k++) begin
        emit(enc(op_ldi, 2, 0, $random(seed) % 250000));
        emit(enc(op_st, 2, 1, 2 * k));
        emit(enc(op_ld, 3, 1, 2 * k));         // read back through the base
        emit(enc(op_ld, 4, 0, 'h300 + 2 * k)); // and through r0, absolute
        emit(enc3(op_add, 5, 3, 4));
        emit(enc(op_st, 5, 1, 2 * k + 1));
    end
    emit(enc(op_ld, 6, 1, -'h80));   // negative offset into the fill area
    emit(enc(op_st, 6, 0, 'h320));
    emit(enc(op_ld, 7, 0, 'h3f0));
    emit(enc(op_st, 7, 1, 'h21));
    emit(enc(op_halt, 0, 0, 0));
endtask

task automatic program_branches();
    int vals [8] = '{0, 5, 7, 0, 3, -4, -1, 9};   // taken, not taken per condition
    int k;
    for (k = 0; k < 8; k++) begin
        emit(enc(op_ldi, 1, 0, vals[k]));
        emit(enc(op_ldi, 2, 0, 'h100 + k));       // marker for the skippable store
        emit(enc(op_br, 1, k / 2, 1));
        emit(enc(op_st, 2, 0, 'h380 + 2 * k));
        emit(enc(op_st, 1, 0, 'h381 + 2 * k));
    end
    emit(enc(op_br, 2, br_nonzero, 2));           // jump over a store and a halt
    emit(enc(op_st, 2, 0, 'h3a0));
    emit(enc(op_halt, 0, 0, 0));
    emit(enc(op_st, 2, 0, 'h3a1));
    emit(enc(op_halt, 0, 0, 0));
endtask

// interprets the program in mem, returns the store count or -1 without halt
function automatic int ref_run();
    logic [31:0] r [16];
    logic [31:0] w;
    logic [31:0] c;
    logic [31:0] ea;
    logic [9:0]  pc;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic        taken;
    int          step;
    ref_image = mem;
    exp_addr.delete();
    exp_data.delete();
    r = '{default: '0};
    pc = '0;
    for (step = 0; step < 5000; step++) begin
        w = ref_image[pc];
        pc = pc + 10'd1;
        ra = w[26:23];
        rb = w[22:19];
        rc = w[18:15];
        c = {{13{w[18]}}, w[18:0]};
        ea = ((rb == 4'd0) ? 32'd0 : r[rb]) + c;   // r0 as base means zero
        case (opcode_e'(w[31:27]))
            op_ld:   r[ra] = ref_image[ea[9:0]];
            op_ldi:  r[ra] = ea;
            op_st: begin
                ref_image[ea[9:0]] = r[ra];
                exp_addr.push_back({22'd0, ea[9:0]});
                exp_data.push_back(r[ra]);
            end
            op_add:  r[ra] = r[rb] + r[rc];
            op_sub:  r[ra] = r[rb] - r[rc];
            op_and:  r[ra] = r[rb] & r[rc];
            op_or:   r[ra] = r[rb] | r[rc];
            op_addi: r[ra] = r[rb] + c;
            op_neg:  r[ra] = -r[rb];
            op_not:  r[ra] = ~r[rb];
            op_br: begin
                case (br_cond_e'(w[20:19]))
                    br_zero:    taken = (r[ra] == 32'd0);
                    br_nonzero: taken = (r[ra] != 32'd0);
                    br_plus:    taken = !r[ra][31];
                    default:    taken = r[ra][31];
                endcase
                if (taken) pc = pc + c[9:0];   // relative to the next word
            end
            op_halt: return exp_addr.size();
            default: ;
        endcase
    end
    return -1;
endfunction

`endif

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int HALT_TIMEOUT = 5000;
    localparam int ACK_TIMEOUT  = 16;
    localparam int IDLE_WINDOW  = 40;

    logic     clk;
    logic     reset;
    logic     mem_req;
    mem_req_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;
    logic     halted;

    logic [31:0] mem [MEM_WORDS];
    integer      seed = 74130;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          transfers = 0;
    int          dut_stores;
    logic        expect_first;

    `include "cpu_ref.svh"

    cpu_top dut_i (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_cmd(mem_cmd),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic fill_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc3a5_0000 ^ (32'(i) * 32'h0001_0003);
        end
        pc_w = 0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        expect_first = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        compare_values("halted", halted, 1'b0);
        compare_values("mem_req", mem_req, 1'b0);
        reset = 1'b0;
    endtask

    task automatic check_store();
        dut_stores++;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("store to address 0x%0h that the program does not make", mem_cmd.addr);
        end else begin
            compare_values("mem_cmd.addr", mem_cmd.addr, exp_addr.pop_front());
            compare_values("mem_cmd.wdata", mem_cmd.wdata, exp_data.pop_front());
        end
    endtask

    task automatic run_test(input string name, input int which);
        int start_errors;
        int ref_count;
        int n;
        start_errors = errors;
        fill_memory();
        case (which)
            0:       program_arith();
            1:       program_load_store();
            default: program_branches();
        endcase
        ref_count = ref_run();
        if (ref_count < 0) begin
            errors++;
            $display("reference run of %s never reached halt", name);
        end
        dut_stores = 0;
        apply_reset();
        n = 0;
        while (!halted && n < HALT_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!halted) begin
            errors++;
            $display("%s timed out waiting for halted", name);
        end else begin
            for (n = 0; n < IDLE_WINDOW; n++) begin   // machine must stay quiet
                @(posedge clk);
                #2;
                compare_values("halted", halted, 1'b1);
                compare_values("mem_req", mem_req, 1'b0);
            end
        end
        compare_values("store count", dut_stores, ref_count);
        for (n = 0; n < MEM_WORDS; n++) begin
            compare_values($sformatf("mem[0x%0h]", n), mem[n], ref_image[n]);
        end
        tests_run++;
        if (errors != start_errors) tests_failed++;
        $display("test %s: %s, %0d stores", name,
                 (errors == start_errors) ? "ok" : "FAILED", dut_stores);
    endtask

    // answers each request after 0 to 3 clocks, ack lingers 0 to 7 more
    initial begin : memory_model
        int delay;
        int n;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req && !mem_ack && !reset) begin
                delay = $random(seed) & 3;
                for (n = 0; n < delay; n++) begin
                    @(posedge clk);
                    #2;
                end
                if (mem_cmd.write) mem[mem_cmd.addr[9:0]] = mem_cmd.wdata;
                else mem_rdata = mem[mem_cmd.addr[9:0]];
                mem_ack = 1'b1;
                for (n = 0; n < ACK_TIMEOUT && mem_req; n++) begin
                    @(posedge clk);
                    #2;
                end
                if (mem_req) begin
                    errors++;
                    $display("mem_req was not released after ack at %0t", $time);
                end
                delay = $random(seed) & 7;   // slow release of ack
                for (n = 0; n < delay; n++) begin
                    @(posedge clk);
                    #2;
                end
                mem_ack = 1'b0;
            end
        end
    end

    // handshake rules and store log, sampled mid-cycle
    initial begin : handshake_monitor
        logic     prev_req;
        logic     prev_ack;
        mem_req_t held_cmd;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        held_cmd = '0;
        forever begin
            @(negedge clk);
            if (reset) begin
                prev_req = 1'b0;
            end else begin
                if (mem_req && !prev_req) begin
                    compare_values("mem_ack at request", prev_ack, 1'b0);  // ack as the DUT saw it
                    held_cmd = mem_cmd;
                    if (expect_first) begin
                        compare_values("mem_cmd.addr", mem_cmd.addr, 0);
                        compare_values("mem_cmd.write", mem_cmd.write, 1'b0);
                        expect_first = 1'b0;
                    end
                end else if (mem_req) begin
                    compare_values("mem_cmd", mem_cmd, held_cmd);
                end
                if (mem_req && mem_ack) begin
                    transfers++;
                    if (mem_cmd.write) check_store();
                end
                prev_req = mem_req;
            end
            prev_ack = mem_ack;
        end
    end

    initial begin
        reset = 1'b1;
        expect_first = 1'b0;
        run_test("arith_logic", 0);
        run_test("load_store", 1);
        run_test("branches", 2);
        $display("tests %0d, failed %0d, transfers %0d, errors %0d",
                 tests_run, tests_failed, transfers, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/control_unit.sv
src/reg_file.sv
src/alu_unit.sv
src/ir_pc_unit.sv
src/bus_interface.sv
src/cpu_top.sv
dv/cpu_tb.sv

//--- src/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  cpu_isa_pkg::word_t  bus,
    output cpu_isa_pkg::word_t  zlo_value
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t   y_q;
    word_t   z_q;
    word_t   result;
    alu_op_e op;

    // fetch forces the increment whatever alu_op says
    assign op = ctrl.pc_increment ? alu_inc : ctrl.alu_op;

    always_comb begin
        case (op)
            alu_add: result = y_q + bus;
            alu_sub: result = y_q - bus;
            alu_and: result = y_q & bus;
            alu_or:  result = y_q | bus;
            alu_neg: result = -bus;       // bus only
            alu_not: result = ~bus;
            alu_inc: result = bus + 1'b1;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y_q <= '0;
        end else if (ctrl.y_clr) begin
            y_q <= '0;
        end else if (ctrl.y_enable) begin
            y_q <= bus;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            z_q <= '0;
        end else if (ctrl.z_enable) begin
            z_q <= result;   // low word only
        end
    end

    assign zlo_value = z_q;

endmodule

`default_nettype wire

//--- src/bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module bus_interface #(
    parameter int ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_ctrl_pkg::ctrl_t    ctrl,
    input  cpu_isa_pkg::word_t     reg_value,
    input  cpu_isa_pkg::word_t     pc_value,
    input  cpu_isa_pkg::word_t     const_value,
    input  cpu_isa_pkg::word_t     zlo_value,
    output cpu_isa_pkg::word_t     bus,
    output logic                   mem_req,
    output cpu_ctrl_pkg::mem_req_t mem_cmd,
    input  logic                   mem_ack,
    input  cpu_isa_pkg::word_t     mem_rdata,
    output logic                   mem_done
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    typedef enum logic [1:0] {hs_idle, hs_req, hs_release} hs_state_e;

    hs_state_e         hs;
    logic [ADDR_W-1:0] mar;
    word_t             mdr;
    logic              write_q;

    always_comb begin
        case (ctrl.bus_src)
            src_reg:   bus = reg_value;
            src_pc:    bus = pc_value;
            src_mdr:   bus = mdr;
            src_zlo:   bus = zlo_value;
            src_const: bus = const_value;
            default:   bus = '0;   // nothing driving
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs       <= hs_idle;
            mar      <= '0;
            mdr      <= '0;
            write_q  <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (ctrl.mar_enable) mar <= bus[ADDR_W-1:0];
            if (ctrl.mdr_enable) mdr <= bus;
            case (hs)
                hs_idle: if (ctrl.mem_read || ctrl.mem_write) begin
                    hs      <= hs_req;
                    write_q <= ctrl.mem_write;
                end
                hs_req: if (mem_ack) begin
                    if (!write_q) mdr <= mem_rdata;   // read data at ack
                    hs <= hs_release;
                end
                hs_release: if (!mem_ack) begin
                    // ack seen low, next request may start
                    mem_done <= 1'b1;
                    hs       <= hs_idle;
                end
                default: hs <= hs_idle;
            endcase
        end
    end

    assign mem_req = (hs == hs_req);

    // MAR and MDR hold still while the request is up
    always_comb begin
        mem_cmd       = '0;
        mem_cmd.addr  = MEM_ADDR_W'(mar);
        mem_cmd.wdata = mdr;
        mem_cmd.write = write_q;
    end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                clk,
    input  logic                reset,
    input  cpu_isa_pkg::instr_t instr,
    input  logic                con_ff,
    input  logic                mem_done,
    output cpu_ctrl_pkg::ctrl_t ctrl,
    output logic                halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    state_e state;
    state_e ret_state;   // where mem_wait goes once the transfer is done

    function automatic state_e decode(opcode_e op);
        case (op)
            op_ld:                          return ld3;
            op_ldi:                         return ldi3;
            op_st:                          return st3;
            op_add, op_sub, op_and, op_or:  return alu3;
            op_addi:                        return addi3;
            op_neg, op_not:                 return neg_not3;
            op_br:                          return br3;
            op_halt:                        return halt_s;
            default:                        return fetch0;   // nop, unknown
        endcase
    endfunction

    function automatic alu_op_e alu_of(opcode_e op);
        case (op)
            op_sub:  return alu_sub;
            op_and:  return alu_and;
            op_or:   return alu_or;
            op_neg:  return alu_neg;
            op_not:  return alu_not;
            default: return alu_add;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= reset_s;
            ret_state <= reset_s;
        end else begin
            case (state)
                reset_s:  state <= fetch0;
                fetch0:   state <= fetch1;
                fetch1: begin
                    state     <= mem_wait;
                    ret_state <= fetch2;
                end
                fetch2:   state <= decode(instr.opcode);   // instr shows the word being loaded
                mem_wait: if (mem_done) state <= ret_state;
                ld3:      state <= ld4;
                ld4:      state <= ld5;
                ld5:      state <= ld6;
                ld6: begin
                    state     <= mem_wait;
                    ret_state <= ld7;
                end
                ldi3:     state <= ldi4;
                ldi4:     state <= ldi5;
                st3:      state <= st4;
                st4:      state <= st5;
                st5:      state <= st6;
                st6: begin
                    state     <= mem_wait;
                    ret_state <= fetch0;
                end
                alu3:     state <= alu4;
                alu4:     state <= alu5;
                addi3:    state <= addi4;
                addi4:    state <= addi5;
                neg_not3: state <= neg_not4;
                br3:      state <= br4;
                br4:      state <= br5;
                br5:      state <= br6;
                halt_s:   state <= halt_s;
                default:  state <= fetch0;   // last step of every instruction
            endcase
        end
    end

    // one control word per state
    always_comb begin
        ctrl = '0;
        case (state)
            fetch0: begin
                ctrl.bus_src      = src_pc;
                ctrl.mar_enable   = 1'b1;
                ctrl.pc_increment = 1'b1;    // Z gets PC + 1
                ctrl.y_clr        = 1'b1;
                ctrl.z_enable     = 1'b1;
            end
            fetch1: begin
                ctrl.bus_src   = src_zlo;
                ctrl.pc_enable = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            fetch2: begin
                ctrl.bus_src   = src_mdr;
                ctrl.ir_enable = 1'b1;
            end
            ld3, ldi3, st3: begin
                ctrl.reg_sel  = sel_grb;
                ctrl.ba_out   = 1'b1;
                ctrl.bus_src  = src_reg;
                ctrl.y_enable = 1'b1;
            end
            ld4, ldi4, st4, addi4, br5: begin
                ctrl.bus_src  = src_const;   // Y + c into Z
                ctrl.alu_op   = alu_add;
                ctrl.z_enable = 1'b1;
            end
            ld5, st5: begin
                ctrl.bus_src    = src_zlo;
                ctrl.mar_enable = 1'b1;
            end
            ld6: ctrl.mem_read = 1'b1;
            ld7: begin
                ctrl.bus_src = src_mdr;
                ctrl.reg_sel = sel_gra;
                ctrl.r_in    = 1'b1;
            end
            st6: begin
                ctrl.reg_sel    = sel_gra;
                ctrl.bus_src    = src_reg;
                ctrl.mdr_enable = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            alu3, addi3: begin
                ctrl.reg_sel  = sel_grb;
                ctrl.bus_src  = src_reg;
                ctrl.y_enable = 1'b1;
            end
            alu4: begin
                ctrl.reg_sel  = sel_grc;
                ctrl.bus_src  = src_reg;
                ctrl.alu_op   = alu_of(instr.opcode);
                ctrl.z_enable = 1'b1;
            end
            neg_not3: begin
                ctrl.reg_sel  = sel_grb;
                ctrl.bus_src  = src_reg;
                ctrl.alu_op   = alu_of(instr.opcode);
                ctrl.z_enable = 1'b1;
            end
            ldi5, alu5, addi5, neg_not4: begin
                ctrl.bus_src = src_zlo;
                ctrl.reg_sel = sel_gra;
                ctrl.r_in    = 1'b1;
            end
            br3: begin
                ctrl.reg_sel    = sel_gra;
                ctrl.bus_src    = src_reg;
                ctrl.con_enable = 1'b1;
            end
            br4: begin
                ctrl.bus_src  = src_pc;
                ctrl.y_enable = 1'b1;
            end
            br6: begin
                ctrl.bus_src   = src_zlo;
                ctrl.pc_enable = con_ff;     // taken only when the test passed
            end
            default: ;
        endcase
    end

    assign halted = (state == halt_s);

endmodule

`default_nettype wire

//--- src/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    localparam int MEM_ADDR_W = 16;   // address width on the memory port

    typedef enum logic [5:0] {
        reset_s,
        fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        st3, st4, st5, st6,
        alu3, alu4, alu5,
        addi3, addi4, addi5,
        neg_not3, neg_not4,
        br3, br4, br5, br6,
        mem_wait,
        halt_s
    } state_e;

    // single driver of the internal bus
    typedef enum logic [2:0] {
        src_none, src_reg, src_pc, src_mdr, src_zlo, src_const
    } bus_src_e;

    typedef enum logic [1:0] {
        sel_gra, sel_grb, sel_grc
    } reg_sel_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_neg, alu_not, alu_inc
    } alu_op_e;

    typedef struct packed {
        bus_src_e bus_src;
        reg_sel_e reg_sel;
        logic     r_in;
        logic     ba_out;      // r0 reads as zero for base addressing
        logic     y_enable;
        logic     y_clr;
        logic     z_enable;
        alu_op_e  alu_op;
        logic     pc_enable;
        logic     pc_increment;
        logic     ir_enable;
        logic     con_enable;
        logic     mar_enable;
        logic     mdr_enable;
        logic     mem_read;
        logic     mem_write;
    } ctrl_t;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        cpu_isa_pkg::word_t    wdata;
        logic                  write;
    } mem_req_t;

endpackage

`default_nettype wire

//--- src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 4;
    localparam int C19_W  = 19;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    // original opcode slots, halt takes the free slot after nop
    typedef enum logic [4:0] {
        op_ld   = 5'b00000,
        op_ldi  = 5'b00001,
        op_st   = 5'b00010,
        op_add  = 5'b00011,
        op_sub  = 5'b00100,
        op_and  = 5'b01010,
        op_or   = 5'b01011,
        op_addi = 5'b01100,
        op_neg  = 5'b10001,
        op_not  = 5'b10010,
        op_br   = 5'b10011,
        op_nop  = 5'b11010,
        op_halt = 5'b11011
    } opcode_e;

    typedef enum logic [1:0] {
        br_zero    = 2'b00,
        br_nonzero = 2'b01,
        br_plus    = 2'b10,   // msb clear, zero counts as plus
        br_minus   = 2'b11
    } br_cond_e;

    // rc overlaps the top of the constant field
    typedef struct packed {
        reg_idx_t               rc;
        logic [C19_W-REG_W-1:0] rest;
    } rc_field_t;

    typedef union packed {
        logic [C19_W-1:0] c19;
        rc_field_t        r;
    } low_field_t;

    typedef struct packed {
        opcode_e    opcode;   // [31:27]
        reg_idx_t   ra;       // [26:23]
        reg_idx_t   rb;       // [22:19], br condition in [20:19]
        low_field_t low;      // [18:0]
    } instr_t;

endpackage

`default_nettype wire

//--- src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   mem_req,
    output cpu_ctrl_pkg::mem_req_t mem_cmd,
    input  logic                   mem_ack,
    input  cpu_isa_pkg::word_t     mem_rdata,
    output logic                   halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_t  ctrl;
    instr_t instr;
    logic   con_ff;
    logic   mem_done;
    word_t  bus;
    word_t  reg_value;
    word_t  pc_value;
    word_t  const_value;
    word_t  zlo_value;

    control_unit control_i (
        .clk(clk), .reset(reset), .instr(instr), .con_ff(con_ff),
        .mem_done(mem_done), .ctrl(ctrl), .halted(halted)
    );

    reg_file reg_file_i (
        .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr),
        .bus(bus), .reg_value(reg_value)
    );

    alu_unit alu_i (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .zlo_value(zlo_value)
    );

    ir_pc_unit #(.ADDR_W(ADDR_W)) ir_pc_i (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .instr(instr),
        .pc_value(pc_value), .const_value(const_value), .con_ff(con_ff)
    );

    bus_interface #(.ADDR_W(ADDR_W)) bus_if_i (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .reg_value(reg_value), .pc_value(pc_value),
        .const_value(const_value), .zlo_value(zlo_value), .bus(bus),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack),
        .mem_rdata(mem_rdata), .mem_done(mem_done)
    );

endmodule

`default_nettype wire

//--- src/ir_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ir_pc_unit #(
    parameter int ADDR_W = 10
) (
    input  logic                clk,
    input  logic                reset,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  cpu_isa_pkg::word_t  bus,
    output cpu_isa_pkg::instr_t instr,
    output cpu_isa_pkg::word_t  pc_value,
    output cpu_isa_pkg::word_t  const_value,
    output logic                con_ff
);
    import cpu_isa_pkg::*;

    logic [ADDR_W-1:0] pc;
    instr_t            ir_q;
    logic              cond_hit;

    // branch test of ra, taken from the bus
    always_comb begin
        case (br_cond_e'(ir_q.rb[1:0]))
            br_zero:    cond_hit = (bus == '0);
            br_nonzero: cond_hit = (bus != '0);
            br_plus:    cond_hit = !bus[WORD_W-1];
            default:    cond_hit = bus[WORD_W-1];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= '0;
            ir_q   <= '0;
            con_ff <= 1'b0;
        end else begin
            if (ctrl.pc_enable)  pc     <= bus[ADDR_W-1:0];   // wraps at ADDR_W
            if (ctrl.ir_enable)  ir_q   <= instr_t'(bus);
            if (ctrl.con_enable) con_ff <= cond_hit;
        end
    end

    // decode in fetch2 sees the word on its way into IR
    assign instr       = ctrl.ir_enable ? instr_t'(bus) : ir_q;
    assign pc_value    = word_t'(pc);
    assign const_value = {{(WORD_W-C19_W){ir_q.low.c19[C19_W-1]}}, ir_q.low.c19};

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  cpu_isa_pkg::instr_t instr,
    input  cpu_isa_pkg::word_t  bus,
    output cpu_isa_pkg::word_t  reg_value
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t    regs [2**REG_W];
    reg_idx_t idx;

    always_comb begin
        case (ctrl.reg_sel)
            sel_grb: idx = instr.rb;
            sel_grc: idx = instr.low.r.rc;
            default: idx = instr.ra;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.r_in) begin
            regs[idx] <= bus;
        end
    end

    // base r0 reads as zero, gives absolute addresses
    assign reg_value = (ctrl.ba_out && idx == '0) ? '0 : regs[idx];

endmodule

`default_nettype wire
